/* hw/isa_pkg.sv */
package isa_pkg;

    // one moved value, and one code word.
    typedef logic [15:0] word_t;

    // destination field, upper six bits of an instruction.
    typedef logic [5:0] dest_addr_t;

    // source field, lower ten bits of an instruction.
    typedef logic [9:0] src_addr_t;

    // flag index for br/bn, taken from the low source bits.
    typedef logic [3:0] flag_sel_t;

    // every instruction is a single move from src to dest.
    typedef struct packed {
        dest_addr_t dest;
        src_addr_t  src;
    } instr_t;

    // destination operators.
    // writing here triggers control behaviour instead of a register load.
    localparam dest_addr_t DEST_BR      = 6'h38;
    localparam dest_addr_t DEST_BN      = 6'h39;
    localparam dest_addr_t DEST_RETADDR = 6'h3e;
    localparam dest_addr_t DEST_RETURN  = 6'h3f;

    // source addresses.
    // registers sit at the bottom of the source space.
    localparam src_addr_t SRC_RETADDR     = 10'h03e;
    // the whole 0x200 block is the 8-bit small constant.
    localparam src_addr_t SRC_SMALL_BLOCK = 10'h200;
    // read-only result registers from 0x300 up.
    localparam src_addr_t SRC_AD0         = 10'h300;
    localparam src_addr_t SRC_AND0        = 10'h330;
    localparam src_addr_t SRC_OR0         = 10'h334;
    localparam src_addr_t SRC_XOR0        = 10'h338;
    localparam src_addr_t SRC_FLAGS       = 10'h340;
    localparam src_addr_t SRC_NEG1        = 10'h360;
    // inline immediate, the next code word is the value.
    localparam src_addr_t SRC_IMM16       = 10'h3a0;

endpackage

/* hw/core_pkg.sv */
package core_pkg;

    // fetch state.
    // a skip state discards the word that sits in the instruction register.
    typedef enum logic [1:0] {
        RUN         = 2'd0,
        SKIP_IMM    = 2'd1,
        SKIP_BRANCH = 2'd2
    } fetch_state_e;

    // strobes of the instruction executing this cycle.
    // all of them are qualified by exec.
    typedef struct packed {
        logic exec;
        logic br;
        logic bn;
        logic ret;
        logic ret_load;
    } exec_ctrl_t;

    // flags word, readable as a source and indexed by br/bn.
    typedef struct packed {
        logic [7:0] ones;
        logic       eq;
        logic       gt;
        logic       lt;
        logic       ad0_zero;
        logic       ad0_carry;
        logic       and0_zero;
        logic [1:0] spare;
    } flags_t;

endpackage

/* hw/fetch_sequencer.sv */
`timescale 1ns/10ps

module fetch_sequencer
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                sysreset,
    input  logic                sysclk,
    input  word_t               code_in,
    input  logic                code_ready,
    input  flags_t              flags,
    output exec_ctrl_t          ctrl,
    output instr_t              instr,
    output logic                branch_taken,
    output logic [NUM_REGS-1:0] r_load,
    output logic [NUM_REGS-1:0] r_read
);

    fetch_state_e state;
    fetch_state_e state_next;
    flag_sel_t    flag_sel;
    logic         flag_bit;
    logic         imm16_exec;

    // decode of the executing instruction.
    always_comb begin
        // nothing executes in reset, during a stall or in a skipped slot.
        ctrl.exec     = !sysclk && code_ready && (state == RUN);
        ctrl.br       = ctrl.exec && (instr.dest == DEST_BR);
        ctrl.bn       = ctrl.exec && (instr.dest == DEST_BN);
        ctrl.ret      = ctrl.exec && (instr.dest == DEST_RETURN);
        ctrl.ret_load = ctrl.exec && (instr.dest == DEST_RETADDR);
        imm16_exec    = ctrl.exec && (instr.src == SRC_IMM16);
    end

    // register file strobes, one cycle wide.
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            r_load[i] = ctrl.exec && (instr.dest == dest_addr_t'(i));
            r_read[i] = ctrl.exec && (instr.src == src_addr_t'(i));
        end
    end

    // branch condition from the selected flag.
    assign flag_sel     = flag_sel_t'(instr.src);
    assign flag_bit     = flags[flag_sel];
    assign branch_taken = (ctrl.br && flag_bit) || (ctrl.bn && !flag_bit);

    always_comb begin
        state_next = state;
        if (code_ready) begin
            case (state)
                RUN: begin
                    // the immediate word is now in the instruction register.
                    if (imm16_exec) begin
                        state_next = SKIP_IMM;
                    // the target slot is loaded either way, taken or not.
                    end else if (ctrl.br || ctrl.bn || ctrl.ret) begin
                        state_next = SKIP_BRANCH;
                    end
                end
                default: state_next = RUN;
            endcase
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            state <= RUN;
            instr <= '0;
        end else if (code_ready) begin
            state <= state_next;
            instr <= instr_t'(code_in);
        end
    end

endmodule

/* hw/ipr_counter.sv */
`timescale 1ns/10ps

module ipr_counter
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int IPR_WIDTH = 16
) (
    input  logic                 sysreset,
    input  logic                 sysclk,
    input  logic                 code_ready,
    input  exec_ctrl_t           ctrl,
    input  logic                 branch_taken,
    input  word_t                code_in,
    input  word_t                move_data,
    output logic [IPR_WIDTH-1:0] code_addr,
    output word_t                return_addr
);

    logic [IPR_WIDTH-1:0] ipr;
    logic [IPR_WIDTH-1:0] ipr_next;

    // the pointer always addresses the word being fetched.
    assign code_addr = ipr;

    always_comb begin
        // on a branch, code_in is the target word fetched behind br/bn.
        if (branch_taken) begin
            ipr_next = IPR_WIDTH'(code_in);
        end else if (ctrl.ret) begin
            ipr_next = IPR_WIDTH'(return_addr);
        end else begin
            ipr_next = ipr + IPR_WIDTH'(1);
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr         <= '0;
            return_addr <= '0;
        end else if (code_ready) begin
            ipr <= ipr_next;
            // return swaps pointer and return address.
            if (ctrl.ret) begin
                return_addr <= word_t'(ipr);
            end else if (ctrl.ret_load) begin
                return_addr <= move_data;
            end
        end
    end

endmodule

/* hw/result_units.sv */
`timescale 1ns/10ps

module result_units
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                 sysreset,
    input  logic                 sysclk,
    input  word_t [NUM_REGS-1:0] r,
    input  logic                 load_operands,
    output word_t                ad0,
    output word_t                and0,
    output word_t                or0,
    output word_t                xor0,
    output flags_t               flags
);

    logic [16:0] ad0_sum;
    word_t       and0_comb;
    logic        load_ad0;
    logic        ad0_carry;
    logic        ad0_zero;
    logic        and0_zero;
    logic        eq0;
    logic        gt0;
    logic        lt0;

    // r0 and r1 are the operands of every unit here.
    // the stored carry chains one add into the next.
    assign ad0_sum   = {1'b0, r[0]} + {1'b0, r[1]} + 17'(ad0_carry);
    assign and0_comb = r[0] & r[1];

    // adder ad0.
    // loads one clock after an operand write, when r holds the new value.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            load_ad0  <= 1'b0;
            ad0       <= '0;
            ad0_carry <= 1'b0;
            ad0_zero  <= 1'b0;
        end else begin
            load_ad0 <= load_operands;
            if (load_ad0) begin
                ad0       <= ad0_sum[15:0];
                ad0_carry <= ad0_sum[16];
                ad0_zero  <= ~|ad0_sum[15:0];
            end
        end
    end

    // bitwise results, free running.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            and0 <= '0;
            or0  <= '0;
            xor0 <= '0;
        end else begin
            and0 <= and0_comb;
            or0  <= r[0] | r[1];
            xor0 <= r[0] ^ r[1];
        end
    end

    // comparator and and0 zero flag.
    // lt is derived from last cycle's eq and gt, so it lags one clock.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            and0_zero <= 1'b0;
            eq0       <= 1'b0;
            gt0       <= 1'b0;
            lt0       <= 1'b0;
        end else begin
            and0_zero <= ~|and0_comb;
            eq0       <= (r[0] == r[1]);
            gt0       <= (r[0] > r[1]);
            lt0       <= !(eq0 || gt0);
        end
    end

    assign flags = '{
        ones:      8'hff,
        eq:        eq0,
        gt:        gt0,
        lt:        lt0,
        ad0_zero:  ad0_zero,
        ad0_carry: ad0_carry,
        and0_zero: and0_zero,
        spare:     2'b00
    };

endmodule

/* hw/source_mux.sv */
`timescale 1ns/10ps

module source_mux
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  instr_t               instr,
    input  word_t [NUM_REGS-1:0] r,
    input  word_t                code_in,
    input  word_t                return_addr,
    input  word_t                ad0,
    input  word_t                and0,
    input  word_t                or0,
    input  word_t                xor0,
    input  flags_t               flags,
    output word_t                move_data
);

    always_comb begin
        move_data = '0;
        // register file at the bottom of the source space.
        if (instr.src < src_addr_t'(NUM_REGS)) begin
            move_data = r[instr.src];
        // small constant, the low byte of the instruction itself.
        end else if (instr.src[9:8] == SRC_SMALL_BLOCK[9:8]) begin
            move_data = {8'h00, instr.src[7:0]};
        end else begin
            case (instr.src)
                SRC_RETADDR: move_data = return_addr;
                SRC_AD0:     move_data = ad0;
                SRC_AND0:    move_data = and0;
                SRC_OR0:     move_data = or0;
                SRC_XOR0:    move_data = xor0;
                SRC_FLAGS:   move_data = word_t'(flags);
                SRC_NEG1:    move_data = '1;
                // the next code word is on code_in this cycle.
                SRC_IMM16:   move_data = code_in;
                // unmapped sources read as zero.
                default:     move_data = '0;
            endcase
        end
    end

endmodule

/* hw/synapse316_core.sv */
`timescale 1ns/10ps

module synapse316_core
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int IPR_WIDTH = 16,
    parameter int NUM_REGS  = 8
) (
    input  logic                 sysreset,
    input  logic                 sysclk,
    output logic [IPR_WIDTH-1:0] code_addr,
    input  word_t                code_in,
    input  logic                 code_ready,
    input  word_t [NUM_REGS-1:0] r,
    output logic [NUM_REGS-1:0]  r_read,
    output logic [NUM_REGS-1:0]  r_load,
    output word_t                r_load_data
);

    exec_ctrl_t ctrl;
    instr_t     instr;
    logic       branch_taken;
    logic       load_operands;
    word_t      return_addr;
    word_t      move_data;
    word_t      ad0;
    word_t      and0;
    word_t      or0;
    word_t      xor0;
    flags_t     flags;

    // every move writes the mux output.
    assign r_load_data = move_data;
    // r0 and r1 feed the result units.
    assign load_operands = r_load[0] | r_load[1];

    fetch_sequencer #(
        .NUM_REGS (NUM_REGS)
    ) u_fetch_sequencer (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .code_in      (code_in),
        .code_ready   (code_ready),
        .flags        (flags),
        .ctrl         (ctrl),
        .instr        (instr),
        .branch_taken (branch_taken),
        .r_load       (r_load),
        .r_read       (r_read)
    );

    ipr_counter #(
        .IPR_WIDTH (IPR_WIDTH)
    ) u_ipr_counter (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .code_ready   (code_ready),
        .ctrl         (ctrl),
        .branch_taken (branch_taken),
        .code_in      (code_in),
        .move_data    (move_data),
        .code_addr    (code_addr),
        .return_addr  (return_addr)
    );

    result_units #(
        .NUM_REGS (NUM_REGS)
    ) u_result_units (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .r             (r),
        .load_operands (load_operands),
        .ad0           (ad0),
        .and0          (and0),
        .or0           (or0),
        .xor0          (xor0),
        .flags         (flags)
    );

    source_mux #(
        .NUM_REGS (NUM_REGS)
    ) u_source_mux (
        .instr       (instr),
        .r           (r),
        .code_in     (code_in),
        .return_addr (return_addr),
        .ad0         (ad0),
        .and0        (and0),
        .or0         (or0),
        .xor0        (xor0),
        .flags       (flags),
        .move_data   (move_data)
    );

endmodule

/* sim/synapse316_sva.sv */
`timescale 1ns/10ps

module synapse316_sva
    import isa_pkg::*;
    import core_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input logic                sysreset,
    input logic                sysclk,
    input logic                code_ready,
    input instr_t              instr,
    input exec_ctrl_t          ctrl,
    input logic [NUM_REGS-1:0] r_load
);

    logic skip_start;
    logic skip_due;

    // an executed imm16 move, branch or return gives up the next ready slot.
    assign skip_start = ctrl.br || ctrl.bn || ctrl.ret ||
                        (ctrl.exec && (instr.src == SRC_IMM16));

    // the slot to give up is the next ready cycle, however long the stall.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            skip_due <= 1'b0;
        end else if (code_ready) begin
            skip_due <= skip_start;
        end
    end

    // sysreset is the clock and sysclk the reset of this core.
    // every strobe stays low while reset is held.
    strobes_low_in_reset: assert property (
        @(posedge sysreset) sysclk |-> (ctrl == '0) && (r_load == '0)
    ) else $error("strobes active while reset is held");

    // a skip state consumes a ready cycle without executing.
    no_exec_in_skip: assert property (
        @(posedge sysreset) disable iff (sysclk) skip_due |-> !ctrl.exec
    ) else $error("instruction executed in a skipped slot");

    // a stalled memory freezes the instruction register.
    instr_holds_in_stall: assert property (
        @(posedge sysreset) disable iff (sysclk) !code_ready |=> $stable(instr)
    ) else $error("instruction register changed while code_ready was low");

endmodule

bind fetch_sequencer synapse316_sva #(
    .NUM_REGS (NUM_REGS)
) u_sva (
    .sysreset   (sysreset),
    .sysclk     (sysclk),
    .code_ready (code_ready),
    .instr      (instr),
    .ctrl       (ctrl),
    .r_load     (r_load)
);

/* sim/synapse316_tb.sv */
`timescale 1ns/10ps

module synapse316_tb
    import isa_pkg::*;
();

    localparam int IPR_WIDTH  = 16;
    localparam int NUM_REGS   = 8;
    localparam int NUM_TESTS  = 5;
    localparam int PROG_LEN   = 20;
    localparam int MAX_WR     = 18;
    // each entry runs once without stalls and once with random stalls.
    localparam int MAX_CYCLES = 2 * NUM_TESTS * 200;
    localparam logic [31:0] LFSR_SEED = 32'h9fd60688;

    // programs, zero padded.
    // each one ends in a br on the ones flag (bit 8) back to itself.
    localparam word_t PROGS [NUM_TESTS][PROG_LEN] = '{
        // small constant, imm16 with a would-be r7 write as value, -1, register move.
        '{16'h0a5a, 16'h0fa0, 16'h1c05, 16'h1360, 16'h1402, 16'he008, 16'h0005, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000},
        // ad0 with carry out, a second add that takes the stored carry, then and0/or0/xor0.
        '{16'h03a0, 16'hfff0, 16'h07a0, 16'h0020, 16'h0b00, 16'h0201, 16'h1677, 16'h1300,
          16'h1b40, 16'h026c, 16'h065a, 16'h0a99, 16'h1730, 16'h1b34, 16'h1f38, 16'he008,
          16'h000f, 16'h0000, 16'h0000, 16'h0000},
        // flags word for eq, gt, lt and the zero flags.
        '{16'h020c, 16'h060c, 16'h0a11, 16'h0e22, 16'h1340, 16'h0603, 16'h1633, 16'h1a44,
          16'h1740, 16'h0200, 16'h1a55, 16'h1e66, 16'h1f40, 16'h0600, 16'h0a01, 16'h0e02,
          16'h1340, 16'he008, 16'h0011, 16'h0000},
        // br/bn on eq and gt, taken and not taken.
        '{16'h0205, 16'h0605, 16'h0a01, 16'h0e02, 16'he007, 16'h0008, 16'h1eee, 16'h1eef,
          16'h12a1, 16'he407, 16'h000e, 16'h16b2, 16'he006, 16'h0009, 16'he406, 16'h0011,
          16'h1edd, 16'h1ac3, 16'he008, 16'h0012},
        // call through 0x3e and the return operator, then return.
        '{16'hfa06, 16'h0a21, 16'hfc00, 16'h0e32, 16'he008, 16'h0004, 16'h1243, 16'h143e,
          16'hfc00, 16'h1e7f, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000}
    };

    // expected writes as {index, value}.
    // the first is always r0 from the all-zero instruction left by reset.
    localparam logic [19:0] EXPS [NUM_TESTS][MAX_WR] = '{
        '{20'h0_0000, 20'h2_005a, 20'h3_1c05, 20'h4_ffff, 20'h5_005a, 20'h0_0000,
          20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000,
          20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000},
        '{20'h0_0000, 20'h0_fff0, 20'h1_0020, 20'h2_0010, 20'h0_0001, 20'h5_0077,
          20'h4_0022, 20'h6_ff24, 20'h0_006c, 20'h1_005a, 20'h2_0099, 20'h5_0048,
          20'h6_007e, 20'h7_0036, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000},
        '{20'h0_0000, 20'h0_000c, 20'h1_000c, 20'h2_0011, 20'h3_0022, 20'h4_ff80,
          20'h1_0003, 20'h5_0033, 20'h6_0044, 20'h5_ff44, 20'h0_0000, 20'h6_0055,
          20'h7_0066, 20'h7_ff24, 20'h1_0000, 20'h2_0001, 20'h3_0002, 20'h4_ff94},
        '{20'h0_0000, 20'h0_0005, 20'h1_0005, 20'h2_0001, 20'h3_0002, 20'h4_00a1,
          20'h5_00b2, 20'h6_00c3, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000,
          20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000},
        '{20'h0_0000, 20'h2_0021, 20'h4_0043, 20'h5_0003, 20'h3_0032, 20'h0_0000,
          20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000,
          20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000, 20'h0_0000}
    };
    localparam int EXP_COUNT [NUM_TESTS] = '{5, 14, 18, 8, 5};
    // executed moves with a register source, branches and returns included.
    localparam int EXP_READS [NUM_TESTS] = '{2, 1, 1, 5, 3};

    // sysreset is the clock, sysclk the reset.
    logic                 sysreset;
    logic                 sysclk;
    logic [IPR_WIDTH-1:0] code_addr;
    word_t                code_in;
    logic                 code_ready;
    word_t [NUM_REGS-1:0] regs;
    logic [NUM_REGS-1:0]  r_read;
    logic [NUM_REGS-1:0]  r_load;
    word_t                r_load_data;

    word_t       code_mem [PROG_LEN];
    logic [31:0] lfsr;
    logic [19:0] exp_entry;
    logic        checking;
    int          cur_test;
    int          wr_count;
    int          exp_count;
    int          obs_idx;
    int          rd_idx;
    int          rd_count;
    int          cycle_count;
    int          fail_count;

    synapse316_core #(
        .IPR_WIDTH (IPR_WIDTH),
        .NUM_REGS  (NUM_REGS)
    ) DUT (
        .sysreset    (sysreset),
        .sysclk      (sysclk),
        .code_addr   (code_addr),
        .code_in     (code_in),
        .code_ready  (code_ready),
        .r           (regs),
        .r_read      (r_read),
        .r_load      (r_load),
        .r_load_data (r_load_data)
    );

    initial begin
        sysreset = 1'b0;
        forever #4 sysreset = ~sysreset;
    end

    // code memory answers in the same cycle.
    assign code_in = (code_addr < PROG_LEN) ? code_mem[code_addr] : '0;

    // external register file.
    always @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (r_load[i]) begin
                    regs[i] <= r_load_data;
                end
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int onehot_index(input logic [NUM_REGS-1:0] v);
        int idx;
        idx = -1;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (v[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic abort_run(input string why);
        fail_count++;
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // one lfsr bit per stalled cycle.
    task automatic drive_ready(input bit stall);
        if (stall) begin
            lfsr       = lfsr_next(lfsr);
            code_ready = lfsr[0];
        end else begin
            code_ready = 1'b1;
        end
    endtask

    task automatic run_program(input int t, input bit stall);
        @(posedge sysreset);
        #1;
        sysclk     = 1'b1;
        // ready is held high in reset, and still nothing may execute.
        code_ready = 1'b1;
        checking   = 1'b0;
        cur_test   = t;
        for (int a = 0; a < PROG_LEN; a++) begin
            code_mem[a] = PROGS[t][a];
        end
        repeat (8) @(posedge sysreset);
        #1;
        sysclk    = 1'b0;
        wr_count  = 0;
        rd_count  = 0;
        exp_count = EXP_COUNT[t];
        checking  = 1'b1;
        while (wr_count < exp_count) begin
            drive_ready(stall);
            @(posedge sysreset);
            #1;
        end
        // the halt loop must not write anything more.
        repeat (16) begin
            drive_ready(stall);
            @(posedge sysreset);
            #1;
        end
        assert (rd_count == EXP_READS[t]) else
            abort_run($sformatf("FAILED at %0t: r_read count expected %0d got %0d",
                                $time, EXP_READS[t], rd_count));
        checking = 1'b0;
    endtask

    // writes are sampled mid-cycle, well away from both edges.
    always @(negedge sysreset) begin
        if (checking && (r_load != '0)) begin
            obs_idx = onehot_index(r_load);
            assert (wr_count < exp_count) else
                abort_run($sformatf("unexpected extra write to r%0d in program %0d",
                                    obs_idx, cur_test));
            exp_entry = EXPS[cur_test][wr_count];
            assert (obs_idx == int'(exp_entry[19:16])) else
                abort_run($sformatf("FAILED at %0t: r_load index expected %0d got %0d",
                                    $time, exp_entry[19:16], obs_idx));
            assert (r_load_data == exp_entry[15:0]) else
                abort_run($sformatf("FAILED at %0t: r_load_data expected %h got %h",
                                    $time, exp_entry[15:0], r_load_data));
            wr_count++;
        end
    end

    // a register read carries the value held in the register model.
    always @(negedge sysreset) begin
        if (checking && (r_read != '0)) begin
            rd_idx = onehot_index(r_read);
            rd_count++;
            assert (r_load_data == regs[rd_idx]) else
                abort_run($sformatf("FAILED at %0t: r_load_data from r%0d expected %h got %h",
                                    $time, rd_idx, regs[rd_idx], r_load_data));
        end
    end

    always @(posedge sysreset) begin
        cycle_count++;
        assert (cycle_count < MAX_CYCLES) else
            abort_run("timeout, the programs did not finish within the cycle limit");
    end

    initial begin
        sysclk      = 1'b1;
        code_ready  = 1'b0;
        regs        = '0;
        checking    = 1'b0;
        cur_test    = 0;
        wr_count    = 0;
        rd_count    = 0;
        exp_count   = 0;
        cycle_count = 0;
        fail_count  = 0;
        lfsr        = LFSR_SEED;
        for (int a = 0; a < PROG_LEN; a++) begin
            code_mem[a] = '0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_program(t, 1'b0);
            run_program(t, 1'b1);
        end
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* synapse316.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_sequencer.sv
hw/ipr_counter.sv
hw/result_units.sv
hw/source_mux.sv
hw/synapse316_core.sv
sim/synapse316_sva.sv
sim/synapse316_tb.sv

/* Bender.yml */
package:
  name: synapse316

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/core_pkg.sv
      - hw/fetch_sequencer.sv
      - hw/ipr_counter.sv
      - hw/result_units.sv
      - hw/source_mux.sv
      - hw/synapse316_core.sv
  - target: simulation
    files:
      - sim/synapse316_sva.sv
      - sim/synapse316_tb.sv
